// ==== sim/ex_stage_input.txt ====
# name op a b imm shamt alu_src reg_dest rt rd reg_write exp_result exp_dest
# every field after the name is hex
add_reg   0 00000005 00000007 00000100 00 0 1 02 03 1 0000000c 03
add_imm   0 00000010 00000007 fffffff0 00 1 0 04 05 1 00000000 04
sub_reg   1 00000003 00000005 00000000 00 0 1 06 07 1 fffffffe 07
and_reg   2 f0f0f0f0 ff00ff00 00000000 00 0 1 01 08 1 f000f000 08
or_imm    3 12340000 ffffffff 00005678 00 1 0 09 01 1 12345678 09
xor_reg   4 aaaaaaaa ffffffff 00000000 00 0 1 01 0a 1 55555555 0a
slt_neg   5 ffffffff 00000001 00000000 00 0 1 01 0b 1 00000001 0b
slt_pos   5 00000001 ffffffff 00000000 00 0 0 0c 01 1 00000000 0c
slt_eq    5 00000004 00000004 00000000 00 0 1 01 17 1 00000000 17
sll_reg   6 00000000 00000003 00000000 04 0 1 01 0d 1 00000030 0d
srl_reg   7 00000000 80000000 00000000 1f 0 1 01 0e 1 00000001 0e
srl_zero  7 00000000 deadbeef 00000000 00 0 1 01 16 0 deadbeef 16
sra_reg   8 00000000 80000000 00000000 04 0 1 01 0f 1 f8000000 0f
sra_imm   8 00000000 00000000 fffffff0 02 1 0 10 01 1 fffffffc 10
mul_small 9 00000007 00000006 00000000 00 0 1 01 11 1 0000002a 11
add_next  0 00000001 00000002 00000000 00 0 1 01 12 0 00000003 12
mul_neg   9 fffffffd 00000005 00000000 00 0 1 01 13 1 fffffff1 13
mul_wrap  9 00012345 00010000 00000000 00 0 1 01 14 1 23450000 14
mul_imm   9 fffffffe 00000009 fffffffd 00 1 0 15 01 1 00000006 15
sub_imm   1 00000000 00000005 00000001 00 1 0 18 01 1 ffffffff 18

// ==== vlog.f ====
+incdir+design
design/ex_pkg.sv
design/id_ex_reg.sv
design/ex_datapath.sv
design/ex_control.sv
design/mul_step_counter.sv
design/shift_add_multiplier.sv
design/ex_stage_top.sv
sim/clock_gen.sv
sim/tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ex_pkg.sv
      - design/id_ex_reg.sv
      - design/ex_datapath.sv
      - design/ex_control.sv
      - design/mul_step_counter.sv
      - design/shift_add_multiplier.sv
      - design/ex_stage_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/clock_gen.sv
      - sim/tb_ex_stage.sv

// ==== sim/tb_ex_stage.sv ====
`include "ex_config.svh"

module tb_ex_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;

    logic                  i_clock;
    logic                  arst_n;
    logic                  in_valid;
    logic                  in_ready;
    ex_pkg::alu_op_t       in_alu_op;
    ex_pkg::data_t         in_data_a;
    ex_pkg::data_t         in_data_b;
    ex_pkg::data_t         in_immediate;
    logic [`EX_NB_REG-1:0] in_shamt;
    ex_pkg::reg_idx_t      in_rt;
    ex_pkg::reg_idx_t      in_rd;
    logic                  in_alu_src;
    logic                  in_reg_dest;
    logic                  in_reg_write;
    logic                  out_valid;
    logic                  out_ready;
    ex_pkg::data_t         out_result;
    ex_pkg::reg_idx_t      out_dest;
    logic                  out_reg_write;

    // One vector entry per instruction line.
    string                 name_q[$];
    ex_pkg::alu_op_t       op_q[$];
    ex_pkg::data_t         a_q[$];
    ex_pkg::data_t         b_q[$];
    ex_pkg::data_t         imm_q[$];
    logic [`EX_NB_REG-1:0] shamt_q[$];
    logic                  src_q[$];
    logic                  rdst_q[$];
    ex_pkg::reg_idx_t      rt_q[$];
    ex_pkg::reg_idx_t      rd_q[$];
    logic                  wr_q[$];
    ex_pkg::data_t         exp_result_q[$];
    ex_pkg::reg_idx_t      exp_dest_q[$];

    int                    out_idx;
    int                    cycle;
    int                    limit;
    logic                  held;
    ex_pkg::data_t         held_result;
    ex_pkg::reg_idx_t      held_dest;
    logic                  held_reg_write;

    clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clock_gen_inst (
        .i_clock (i_clock),
        .arst_n  (arst_n)
    );

    ex_stage_top ex_stage_top_inst (
        .i_clock       (i_clock),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_alu_op     (in_alu_op),
        .in_data_a     (in_data_a),
        .in_data_b     (in_data_b),
        .in_immediate  (in_immediate),
        .in_shamt      (in_shamt),
        .in_rt         (in_rt),
        .in_rd         (in_rd),
        .in_alu_src    (in_alu_src),
        .in_reg_dest   (in_reg_dest),
        .in_reg_write  (in_reg_write),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_result    (out_result),
        .out_dest      (out_dest),
        .out_reg_write (out_reg_write)
    );

    // ========================================
    // Tasks
    // ========================================

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic load_vectors();
        int                    fd;
        int                    n;
        string                 name;
        string                 rest;
        ex_pkg::alu_op_t       op;
        ex_pkg::data_t         a;
        ex_pkg::data_t         b;
        ex_pkg::data_t         imm;
        ex_pkg::data_t         res;
        logic [`EX_NB_REG-1:0] sh;
        logic                  src;
        logic                  rdst;
        logic                  wr;
        ex_pkg::reg_idx_t      rt;
        ex_pkg::reg_idx_t      rd;
        ex_pkg::reg_idx_t      dst;
        fd = $fopen("sim/ex_stage_input.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open sim/ex_stage_input.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", name);
                if (n == 1 && name[0] == "#") begin
                    n = $fgets(rest, fd); // Column notes.
                end else if (n == 1) begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        op, a, b, imm, sh, src, rdst, rt, rd, wr, res, dst);
                    if (n != 12) begin
                        stop_on_error($sformatf("Line for %s has missing fields", name));
                    end else begin
                        name_q.push_back(name);
                        op_q.push_back(op);
                        a_q.push_back(a);
                        b_q.push_back(b);
                        imm_q.push_back(imm);
                        shamt_q.push_back(sh);
                        src_q.push_back(src);
                        rdst_q.push_back(rdst);
                        rt_q.push_back(rt);
                        rd_q.push_back(rd);
                        wr_q.push_back(wr);
                        exp_result_q.push_back(res);
                        exp_dest_q.push_back(dst);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Each line stays on the inputs until the DUT takes it.
    task automatic drive_vectors();
        int   i;
        logic accepted;
        @(posedge i_clock);
        for (i = 0; i < name_q.size(); i++) begin
            in_valid     <= 1'b1;
            in_alu_op    <= op_q[i];
            in_data_a    <= a_q[i];
            in_data_b    <= b_q[i];
            in_immediate <= imm_q[i];
            in_shamt     <= shamt_q[i];
            in_rt        <= rt_q[i];
            in_rd        <= rd_q[i];
            in_alu_src   <= src_q[i];
            in_reg_dest  <= rdst_q[i];
            in_reg_write <= wr_q[i];
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge i_clock);
                accepted = in_ready;
                @(posedge i_clock);
            end
        end
        in_valid <= 1'b0;
    endtask

    // ========================================
    // Stimulus and run control
    // ========================================

    initial begin
        out_ready = 1'b0;
        void'($urandom(38262));
        forever begin
            @(posedge i_clock);
            out_ready <= ($urandom % 3) != 0; // Ready two times in three.
        end
    end

    initial begin
        in_valid     = 1'b0;
        in_alu_op    = '0;
        in_data_a    = '0;
        in_data_b    = '0;
        in_immediate = '0;
        in_shamt     = '0;
        in_rt        = '0;
        in_rd        = '0;
        in_alu_src   = 1'b0;
        in_reg_dest  = 1'b0;
        in_reg_write = 1'b0;
        out_idx      = 0;
        held         = 1'b0;
        load_vectors();
        limit = name_q.size() * (`EX_MUL_STEPS + 3) * 4 + RESET_CYCLES;
        @(posedge arst_n);
        @(posedge i_clock);
        @(negedge i_clock);
        assert (in_ready === 1'b1)
        else stop_on_error("in_ready was not high on the first cycle after reset");
        fork
            drive_vectors();
        join_none
        cycle = 0;
        while (out_idx < name_q.size() && cycle < limit) begin
            @(posedge i_clock);
            cycle++;
        end
        if (out_idx < name_q.size()) begin
            stop_on_error($sformatf("Timeout after %0d cycles with %0d of %0d results received",
                cycle, out_idx, name_q.size()));
        end else begin
            repeat (4) @(posedge i_clock); // Room for a stray extra result.
            $display("PASS: all tests");
            $finish;
        end
    end

    // ========================================
    // Output monitor
    // ========================================

    // Sampled mid-cycle when all ports are settled.
    always @(negedge i_clock) begin
        if (!arst_n) begin
            assert (out_valid === 1'b0)
            else stop_on_error("out_valid was high during reset");
        end else begin
            if (held) begin
                assert (out_valid === 1'b1)
                else stop_on_error("out_valid dropped before out_ready was high");
                assert ({out_result, out_dest, out_reg_write}
                        === {held_result, held_dest, held_reg_write})
                else stop_on_error($sformatf(
                    "Mismatch in %s: held output expected %h %h %b, actual %h %h %b",
                    name_q[out_idx], held_result, held_dest, held_reg_write,
                    out_result, out_dest, out_reg_write));
            end
            if (out_valid === 1'b1 && out_ready === 1'b1) begin
                if (out_idx >= name_q.size()) begin
                    stop_on_error("A result arrived after all expected results");
                end else begin
                    assert (out_result === exp_result_q[out_idx])
                    else stop_on_error($sformatf("Mismatch in %s: result expected %h, actual %h",
                        name_q[out_idx], exp_result_q[out_idx], out_result));
                    assert (out_dest === exp_dest_q[out_idx])
                    else stop_on_error($sformatf("Mismatch in %s: dest expected %h, actual %h",
                        name_q[out_idx], exp_dest_q[out_idx], out_dest));
                    assert (out_reg_write === wr_q[out_idx])
                    else stop_on_error($sformatf(
                        "Mismatch in %s: reg_write expected %b, actual %b",
                        name_q[out_idx], wr_q[out_idx], out_reg_write));
                    out_idx++;
                end
            end
            held           = (out_valid === 1'b1) && (out_ready !== 1'b1);
            held_result    = out_result;
            held_dest      = out_dest;
            held_reg_write = out_reg_write;
        end
    end

endmodule

// ==== sim/clock_gen.sv ====
module clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic  i_clock,
    output logic  arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        i_clock = 1'b0;
        forever #10 i_clock = ~i_clock; // 20 ns period.
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clock);
        arst_n <= 1'b1; // Released on a rising edge.
    end

endmodule

// ==== design/ex_stage_top.sv ====
`include "ex_config.svh"

module ex_stage_top (
    input  logic                   i_clock,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  ex_pkg::alu_op_t        in_alu_op,
    input  ex_pkg::data_t          in_data_a,
    input  ex_pkg::data_t          in_data_b,
    input  ex_pkg::data_t          in_immediate,
    input  logic [`EX_NB_REG-1:0]  in_shamt,
    input  ex_pkg::reg_idx_t       in_rt,
    input  ex_pkg::reg_idx_t       in_rd,
    input  logic                   in_alu_src,
    input  logic                   in_reg_dest,
    input  logic                   in_reg_write,
    output logic                   out_valid,
    input  logic                   out_ready,
    output ex_pkg::data_t          out_result,
    output ex_pkg::reg_idx_t       out_dest,
    output logic                   out_reg_write
);

    logic                  ex_valid;
    ex_pkg::alu_op_t       ex_alu_op;
    ex_pkg::data_t         ex_data_a;
    ex_pkg::data_t         ex_data_b;
    ex_pkg::data_t         ex_immediate;
    logic [`EX_NB_REG-1:0] ex_shamt;
    ex_pkg::reg_idx_t      ex_rt;
    ex_pkg::reg_idx_t      ex_rd;
    logic                  ex_alu_src;
    logic                  ex_reg_dest;
    logic                  ex_reg_write;
    logic                  retire;
    logic                  mul_start;
    logic                  mul_step;
    logic                  sel_mul;
    logic                  last_step;
    ex_pkg::data_t         mul_b;
    ex_pkg::data_t         mul_product;

    id_ex_reg id_ex_reg_inst (
        .i_clock      (i_clock),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_alu_op    (in_alu_op),
        .in_data_a    (in_data_a),
        .in_data_b    (in_data_b),
        .in_immediate (in_immediate),
        .in_shamt     (in_shamt),
        .in_rt        (in_rt),
        .in_rd        (in_rd),
        .in_alu_src   (in_alu_src),
        .in_reg_dest  (in_reg_dest),
        .in_reg_write (in_reg_write),
        .retire       (retire),
        .ex_valid     (ex_valid),
        .ex_alu_op    (ex_alu_op),
        .ex_data_a    (ex_data_a),
        .ex_data_b    (ex_data_b),
        .ex_immediate (ex_immediate),
        .ex_shamt     (ex_shamt),
        .ex_rt        (ex_rt),
        .ex_rd        (ex_rd),
        .ex_alu_src   (ex_alu_src),
        .ex_reg_dest  (ex_reg_dest),
        .ex_reg_write (ex_reg_write)
    );

    ex_control ex_control_inst (
        .i_clock   (i_clock),
        .arst_n    (arst_n),
        .ex_valid  (ex_valid),
        .ex_alu_op (ex_alu_op),
        .out_ready (out_ready),
        .last_step (last_step),
        .out_valid (out_valid),
        .retire    (retire),
        .mul_start (mul_start),
        .mul_step  (mul_step),
        .sel_mul   (sel_mul)
    );

    mul_step_counter mul_step_counter_inst (
        .i_clock   (i_clock),
        .arst_n    (arst_n),
        .clear     (mul_start),
        .step      (mul_step),
        .last_step (last_step)
    );

    // Multiplier B follows alu_src like the ALU.
    shift_add_multiplier shift_add_multiplier_inst (
        .i_clock      (i_clock),
        .arst_n       (arst_n),
        .load         (mul_start),
        .step         (mul_step),
        .multiplicand (ex_data_a),
        .multiplier   (mul_b),
        .product      (mul_product)
    );

    ex_datapath ex_datapath_inst (
        .alu_op           (ex_alu_op),
        .data_a           (ex_data_a),
        .data_b           (ex_data_b),
        .immediate        (ex_immediate),
        .shamt            (ex_shamt),
        .rt               (ex_rt),
        .rd               (ex_rd),
        .alu_src          (ex_alu_src),
        .reg_dest         (ex_reg_dest),
        .reg_write        (ex_reg_write),
        .sel_mul          (sel_mul),
        .mul_product      (mul_product),
        .mul_b            (mul_b),
        .result           (out_result),
        .dest             (out_dest),
        .result_reg_write (out_reg_write)
    );

endmodule

// ==== design/shift_add_multiplier.sv ====
module shift_add_multiplier (
    input  logic           i_clock,
    input  logic           arst_n,
    input  logic           load,
    input  logic           step,
    input  ex_pkg::data_t  multiplicand,
    input  ex_pkg::data_t  multiplier,
    output ex_pkg::data_t  product
);

    ex_pkg::data_t mcand; // Shifts left each step.
    ex_pkg::data_t mplier; // Shifts right, LSB picks the add.
    ex_pkg::data_t acc;

    always_ff @(posedge i_clock or negedge arst_n) begin
        if (!arst_n) begin
            mcand  <= '0;
            mplier <= '0;
            acc    <= '0;
        end else if (load) begin
            mcand  <= multiplicand;
            mplier <= multiplier;
            acc    <= '0;
        end else if (step) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Low word only, so signed operands come out right as well.
    assign product = acc;

endmodule

// ==== design/mul_step_counter.sv ====
`include "ex_config.svh"

module mul_step_counter (
    input  logic  i_clock,
    input  logic  arst_n,
    input  logic  clear,
    input  logic  step,
    output logic  last_step
);

    localparam ex_pkg::step_cnt_t LAST_IDX = ex_pkg::step_cnt_t'(`EX_MUL_STEPS - 1);
    localparam ex_pkg::step_cnt_t LIMIT    = ex_pkg::step_cnt_t'(`EX_MUL_STEPS);

    ex_pkg::step_cnt_t count;

    always_ff @(posedge i_clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    assign last_step = step && (count == LAST_IDX); // Final iteration.

    a_step_limit: assert property (@(posedge i_clock) disable iff (!arst_n)
        step |-> count != LIMIT);

endmodule

// ==== design/ex_control.sv ====
module ex_control (
    input  logic             i_clock,
    input  logic             arst_n,
    input  logic             ex_valid,
    input  ex_pkg::alu_op_t  ex_alu_op,
    input  logic             out_ready,
    input  logic             last_step,
    output logic             out_valid,
    output logic             retire,
    output logic             mul_start,
    output logic             mul_step,
    output logic             sel_mul
);

    ex_pkg::ex_state_t state;
    ex_pkg::ex_state_t state_next;
    logic              is_mul;

    assign is_mul = (ex_alu_op == ex_pkg::ALU_MUL);

    // ========================================
    // Next state and outputs
    // ========================================

    always_comb begin
        state_next = state;
        out_valid  = 1'b0;
        mul_start  = 1'b0;
        mul_step   = 1'b0;
        sel_mul    = 1'b0;
        case (state)
            ex_pkg::EX_IDLE: begin
                if (ex_valid && is_mul) begin
                    mul_start  = 1'b1; // Load operands, clear counter.
                    state_next = ex_pkg::EX_MUL_BUSY;
                end else if (ex_valid) begin
                    out_valid = 1'b1; // Single-cycle result.
                end
            end
            ex_pkg::EX_MUL_BUSY: begin
                mul_step = 1'b1;
                if (last_step) begin
                    state_next = ex_pkg::EX_MUL_DONE;
                end
            end
            ex_pkg::EX_MUL_DONE: begin
                out_valid = 1'b1;
                sel_mul   = 1'b1;
                if (out_ready) begin
                    state_next = ex_pkg::EX_IDLE;
                end
            end
            default: state_next = ex_pkg::EX_IDLE;
        endcase
    end

    assign retire = out_valid && out_ready;

    always_ff @(posedge i_clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= ex_pkg::EX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ========================================
    // Checks
    // ========================================

    a_valid_held: assert property (@(posedge i_clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid);

    a_start_idle: assert property (@(posedge i_clock) disable iff (!arst_n)
        mul_start |-> (state == ex_pkg::EX_IDLE) ##1 (state == ex_pkg::EX_MUL_BUSY));

endmodule

// ==== design/ex_datapath.sv ====
`include "ex_config.svh"

module ex_datapath (
    input  ex_pkg::alu_op_t        alu_op,
    input  ex_pkg::data_t          data_a,
    input  ex_pkg::data_t          data_b,
    input  ex_pkg::data_t          immediate,
    input  logic [`EX_NB_REG-1:0]  shamt,
    input  ex_pkg::reg_idx_t       rt,
    input  ex_pkg::reg_idx_t       rd,
    input  logic                   alu_src,
    input  logic                   reg_dest,
    input  logic                   reg_write,
    input  logic                   sel_mul,
    input  ex_pkg::data_t          mul_product,
    output ex_pkg::data_t          mul_b,
    output ex_pkg::data_t          result,
    output ex_pkg::reg_idx_t       dest,
    output logic                   result_reg_write
);

    ex_pkg::data_t op_b;
    ex_pkg::data_t alu_result;

    assign op_b  = alu_src ? immediate : data_b; // Immediate for I-type.
    assign dest  = reg_dest ? rd : rt;
    assign mul_b = op_b;

    // Shifts act on operand B, as MIPS shifts rt.
    always_comb begin
        case (alu_op)
            ex_pkg::ALU_ADD: alu_result = data_a + op_b;
            ex_pkg::ALU_SUB: alu_result = data_a - op_b;
            ex_pkg::ALU_AND: alu_result = data_a & op_b;
            ex_pkg::ALU_OR:  alu_result = data_a | op_b;
            ex_pkg::ALU_XOR: alu_result = data_a ^ op_b;
            ex_pkg::ALU_SLT: alu_result = ex_pkg::data_t'($signed(data_a) < $signed(op_b));
            ex_pkg::ALU_SLL: alu_result = op_b << shamt;
            ex_pkg::ALU_SRL: alu_result = op_b >> shamt;
            ex_pkg::ALU_SRA: alu_result = ex_pkg::data_t'($signed(op_b) >>> shamt);
            default:         alu_result = '0;
        endcase
    end

    assign result           = sel_mul ? mul_product : alu_result;
    assign result_reg_write = reg_write;

endmodule

// ==== design/id_ex_reg.sv ====
`include "ex_config.svh"

module id_ex_reg (
    input  logic                   i_clock,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  ex_pkg::alu_op_t        in_alu_op,
    input  ex_pkg::data_t          in_data_a,
    input  ex_pkg::data_t          in_data_b,
    input  ex_pkg::data_t          in_immediate,
    input  logic [`EX_NB_REG-1:0]  in_shamt,
    input  ex_pkg::reg_idx_t       in_rt,
    input  ex_pkg::reg_idx_t       in_rd,
    input  logic                   in_alu_src,
    input  logic                   in_reg_dest,
    input  logic                   in_reg_write,
    input  logic                   retire,
    output logic                   ex_valid,
    output ex_pkg::alu_op_t        ex_alu_op,
    output ex_pkg::data_t          ex_data_a,
    output ex_pkg::data_t          ex_data_b,
    output ex_pkg::data_t          ex_immediate,
    output logic [`EX_NB_REG-1:0]  ex_shamt,
    output ex_pkg::reg_idx_t       ex_rt,
    output ex_pkg::reg_idx_t       ex_rd,
    output logic                   ex_alu_src,
    output logic                   ex_reg_dest,
    output logic                   ex_reg_write
);

    logic running; // Set on the first edge after reset.
    logic load;

    assign in_ready = running && (!ex_valid || retire);
    assign load     = in_valid && in_ready;

    always_ff @(posedge i_clock or negedge arst_n) begin
        if (!arst_n) begin
            running  <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (load) begin
                ex_valid <= 1'b1;
            end else if (retire) begin
                ex_valid <= 1'b0; // Drained with nothing behind it.
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (load) begin
            ex_alu_op    <= in_alu_op;
            ex_data_a    <= in_data_a;
            ex_data_b    <= in_data_b;
            ex_immediate <= in_immediate;
            ex_shamt     <= in_shamt;
            ex_rt        <= in_rt;
            ex_rd        <= in_rd;
            ex_alu_src   <= in_alu_src;
            ex_reg_dest  <= in_reg_dest;
            ex_reg_write <= in_reg_write;
        end
    end

    // A held entry stays put until execute lets it go.
    a_hold_fields: assert property (@(posedge i_clock) disable iff (!arst_n)
        ex_valid && !retire |=> $stable({ex_alu_op, ex_data_a, ex_data_b, ex_immediate,
            ex_shamt, ex_rt, ex_rd, ex_alu_src, ex_reg_dest, ex_reg_write}));

endmodule

// ==== design/ex_pkg.sv ====
`include "ex_config.svh"

package ex_pkg;

    // ========================================
    // Types
    // ========================================

    typedef logic [`EX_NB_DATA-1:0]   data_t;
    typedef logic [`EX_NB_REG-1:0]    reg_idx_t;
    typedef logic [`EX_NB_ALU_OP-1:0] alu_op_t;

    // Counts 0 to EX_MUL_STEPS inclusive.
    typedef logic [$clog2(`EX_MUL_STEPS + 1)-1:0] step_cnt_t;

    // ========================================
    // Operation codes
    // ========================================

    localparam alu_op_t ALU_ADD = alu_op_t'(0);
    localparam alu_op_t ALU_SUB = alu_op_t'(1);
    localparam alu_op_t ALU_AND = alu_op_t'(2);
    localparam alu_op_t ALU_OR  = alu_op_t'(3);
    localparam alu_op_t ALU_XOR = alu_op_t'(4);
    localparam alu_op_t ALU_SLT = alu_op_t'(5);  // Signed compare.
    localparam alu_op_t ALU_SLL = alu_op_t'(6);
    localparam alu_op_t ALU_SRL = alu_op_t'(7);
    localparam alu_op_t ALU_SRA = alu_op_t'(8);
    localparam alu_op_t ALU_MUL = alu_op_t'(9);  // Multi-cycle.

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_MUL_BUSY,
        EX_MUL_DONE
    } ex_state_t;

endpackage

// ==== design/ex_config.svh ====
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// ========================================
// Execute slice widths
// ========================================

`define EX_NB_DATA    32 // Data word.
`define EX_NB_REG     5  // Register index and shamt.
`define EX_NB_ALU_OP  4  // Operation code.

// One multiplier bit per step.
`define EX_MUL_STEPS  `EX_NB_DATA

`endif
